//--- bench/lsu_checker.sv
`default_nettype none

module lsu_checker
    import lsu_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  ex_mem_t  ex_i,
    input  logic     stall_i,
    input  mem_wb_t  wb_i,
    input  mem_fwd_t fwd_i,
    output int       check_cnt_o,
    output int       err_cnt_o,
    output int       pend_cnt_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // Model of the 16-word test region, indexed by address bits 5:2
    logic [31:0] model_mem [16];
    logic        model_link;
    mem_wb_t     expect_q [$];

    initial begin
        check_cnt_o = 0;
        err_cnt_o = 0;
        pend_cnt_o = 0;
        model_link = 1'b0;
    end

    function automatic mem_wb_t predict(input ex_mem_t item);
        mem_wb_t     r;
        logic [3:0]  idx;
        logic [1:0]  off;
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        logic        misaligned;
        r = '0;
        idx = item.mem_addr[5:2];
        off = item.mem_addr[1:0];
        word = model_mem[idx];
        b = word[8*off +: 8];
        h = word[16*off[1] +: 16];
        r.valid = 1'b1;
        r.waddr = item.waddr;
        case (item.op)
            OP_LD_H, OP_LD_HU, OP_ST_H: misaligned = off[0];
            OP_LD_W, OP_ST_W, OP_LL, OP_SC: misaligned = off != 2'd0;
            default: misaligned = 1'b0;
        endcase
        if (misaligned) begin
            r.excp_ale = 1'b1;
            return r;
        end
        r.wreg = 1'b1;
        case (item.op)
            OP_NOP: begin
                r.wreg = item.wreg;
                r.wdata = item.wdata;
            end
            OP_LD_B:  r.wdata = {{24{b[7]}}, b};
            OP_LD_BU: r.wdata = {24'b0, b};
            OP_LD_H:  r.wdata = {{16{h[15]}}, h};
            OP_LD_HU: r.wdata = {16'b0, h};
            OP_LD_W:  r.wdata = word;
            OP_ST_B: begin
                r.wreg = 1'b0;
                model_mem[idx][8*off +: 8] = item.reg2[7:0];
            end
            OP_ST_H: begin
                r.wreg = 1'b0;
                model_mem[idx][16*off[1] +: 16] = item.reg2[15:0];
            end
            OP_ST_W: begin
                r.wreg = 1'b0;
                model_mem[idx] = item.reg2;
            end
            OP_LL: begin
                r.wdata = word;
                r.llbit_we = 1'b1;
                r.llbit_value = 1'b1;
                model_link = 1'b1;
            end
            default: begin
                // SC succeeds only while the link holds
                if (model_link) begin
                    model_mem[idx] = item.reg2;
                    r.wdata = 32'd1;
                    r.llbit_we = 1'b1;
                    model_link = 1'b0;
                end
            end
        endcase
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        err_cnt_o++;
        $display("error %s: expected 0x%0h, got 0x%0h at %0t ns", name, exp, got, $time);
    endtask

    task automatic compare_result(input mem_wb_t exp, input mem_wb_t got);
        check_cnt_o++;
        if (got.wreg !== exp.wreg) report_mismatch("wb_o.wreg", exp.wreg, got.wreg);
        if (got.waddr !== exp.waddr) report_mismatch("wb_o.waddr", exp.waddr, got.waddr);
        if ((exp.wreg || exp.excp_ale) && got.wdata !== exp.wdata) begin
            report_mismatch("wb_o.wdata", exp.wdata, got.wdata);
        end
        if (got.excp_ale !== exp.excp_ale) begin
            report_mismatch("wb_o.excp_ale", exp.excp_ale, got.excp_ale);
        end
        if (got.llbit_we !== exp.llbit_we) begin
            report_mismatch("wb_o.llbit_we", exp.llbit_we, got.llbit_we);
        end
        if (exp.llbit_we && got.llbit_value !== exp.llbit_value) begin
            report_mismatch("wb_o.llbit_value", exp.llbit_value, got.llbit_value);
        end
    endtask

    // Forwarding shows the item in the stage as it leaves
    task automatic compare_forward(input mem_wb_t exp, input mem_op_e op,
                                   input mem_fwd_t got);
        logic exp_load;
        exp_load = op inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W, OP_LL, OP_SC};
        if (got.is_load !== exp_load) report_mismatch("fwd_o.is_load", exp_load, got.is_load);
        if (got.wreg !== exp.wreg) report_mismatch("fwd_o.wreg", exp.wreg, got.wreg);
        if (got.waddr !== exp.waddr) report_mismatch("fwd_o.waddr", exp.waddr, got.waddr);
        if (exp.wreg && got.wdata !== exp.wdata) begin
            report_mismatch("fwd_o.wdata", exp.wdata, got.wdata);
        end
    endtask

    // Inputs move 10 ns after the rising edge, so the falling edge sees settled values
    always @(negedge clk_i) begin
        mem_wb_t exp_wb;
        if (rst_n_i) begin
            if (wb_i.valid) begin
                if (expect_q.size() == 0) begin
                    err_cnt_o++;
                    $display("Result at %0t ns with no accepted item outstanding", $time);
                end else begin
                    compare_result(expect_q.pop_front(), wb_i);
                end
            end
            if (ex_i.valid && !stall_i) begin
                exp_wb = predict(ex_i);
                compare_forward(exp_wb, ex_i.op, fwd_i);
                expect_q.push_back(exp_wb);
            end
            pend_cnt_o = expect_q.size();
        end
    end

endmodule

`default_nettype wire

//--- bench/lsu_props.sv
`default_nettype none

`include "lsu_cfg.svh"

module lsu_props (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   cyc_i,
    input logic                   stb_i,
    input logic                   we_i,
    input logic                   ack_i,
    input logic [`LSU_ADDR_W-1:0] adr_i,
    input logic [`LSU_DATA_W-1:0] dat_i,
    input logic [`LSU_DATA_W/8-1:0] sel_i,
    input logic                   req_ce_i,
    input logic                   data_ok_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt;

    initial fail_cnt = 0;

    // Cycle and strobe stay up until the slave answers
    stb_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stb_i && !ack_i |=> stb_i && cyc_i)
        else begin
            $error("Strobe or cycle dropped before the acknowledge");
            fail_cnt++;
        end

    ack_needs_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i) ack_i |-> stb_i)
        else begin
            $error("Acknowledge without a strobe");
            fail_cnt++;
        end

    // Master must hold the request until the slave answers
    req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stb_i && !ack_i |=> $stable(adr_i) && $stable(dat_i) && $stable(sel_i) && $stable(we_i))
        else begin
            $error("Request changed while waiting for acknowledge");
            fail_cnt++;
        end

    // Stall is req.ce without data_ok, as in the stage
    quiet_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !cyc_i && !(req_ce_i && !data_ok_i))
        else begin
            $error("Bus cycle or stall right after reset release");
            fail_cnt++;
        end

endmodule

`default_nettype wire

//--- bench/lsu_tb.sv
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_RANDOM = 200;
    localparam int NUM_ITEMS = 16 + 16 + 16 * 12 + 16 * 3 + 9 + 5 + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = NUM_ITEMS * 8 + 100;
    // Region base is 64-byte aligned, the checker indexes it by bits 5:2
    localparam logic [31:0] BASE = 32'h0000_0100;

    logic     clk_i;
    logic     rst_n_i;
    ex_mem_t  ex_i;
    logic     stall_o;
    mem_wb_t  wb_o;
    mem_fwd_t fwd_o;
    int       check_cnt;
    int       err_cnt;
    int       pend_cnt;
    int       assert_fails;
    logic [31:0] rng_state;

    lsu_top lsu_top_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .ex_i    (ex_i),
        .stall_o (stall_o),
        .wb_o    (wb_o),
        .fwd_o   (fwd_o)
    );

    lsu_checker checker_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .ex_i        (ex_i),
        .stall_i     (stall_o),
        .wb_i        (wb_o),
        .fwd_i       (fwd_o),
        .check_cnt_o (check_cnt),
        .err_cnt_o   (err_cnt),
        .pend_cnt_o  (pend_cnt)
    );

    bind wb_master lsu_props props_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .cyc_i     (wb_cyc_o),
        .stb_i     (wb_stb_o),
        .we_i      (wb_we_o),
        .ack_i     (wb_ack_i),
        .adr_i     (wb_adr_o),
        .dat_i     (wb_dat_o),
        .sel_i     (wb_sel_o),
        .req_ce_i  (req_i.ce),
        .data_ok_i (data_ok_o)
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] addr_of(input logic [3:0] word, input logic [1:0] off);
        return BASE + {word, off};
    endfunction

    // Hold the item until an edge accepts it
    task automatic send_item(input mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] data, input logic wreg,
                             input logic [4:0] waddr, input logic [31:0] wdata);
        logic accepted;
        ex_i.valid = 1'b1;
        ex_i.op = op;
        ex_i.mem_addr = addr;
        ex_i.reg2 = data;
        ex_i.wreg = wreg;
        ex_i.waddr = waddr;
        ex_i.wdata = wdata;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk_i);
            accepted = !stall_o;
            @(posedge clk_i);
            #10;
        end
        ex_i.valid = 1'b0;
    endtask

    task automatic send_mem(input mem_op_e op, input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] r;
        logic [31:0] filler;
        r = next_random();
        filler = next_random();
        send_item(op, addr, data, r[0], r[5:1], filler);
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles, the run stopped making progress",
                 TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic [1:0]  off;
        rng_state = 32'd58937;
        rst_n_i = 1'b0;
        ex_i = '0;
        // Idle input holds a load opcode with valid low
        ex_i.op = OP_LD_W;
        repeat (2) @(posedge clk_i);
        #10;
        rst_n_i = 1'b1;
        @(posedge clk_i);
        #10;

        // Fill the region so later loads see defined data
        for (int w = 0; w < 16; w++) begin
            d = next_random();
            send_mem(OP_ST_W, addr_of(w[3:0], 2'd0), d);
        end
        for (int w = 0; w < 16; w++) begin
            send_mem(OP_LD_W, addr_of(w[3:0], 2'd0), 32'd0);
        end

        for (int w = 0; w < 16; w++) begin
            for (int o = 0; o < 4; o++) begin
                send_mem(OP_LD_B, addr_of(w[3:0], o[1:0]), 32'd0);
                send_mem(OP_LD_BU, addr_of(w[3:0], o[1:0]), 32'd0);
                if (o[0] == 1'b0) begin
                    send_mem(OP_LD_H, addr_of(w[3:0], o[1:0]), 32'd0);
                    send_mem(OP_LD_HU, addr_of(w[3:0], o[1:0]), 32'd0);
                end
            end
        end

        // Partial stores, then a word load shows the untouched lanes
        for (int w = 0; w < 16; w++) begin
            r = next_random();
            d = next_random();
            send_mem(OP_ST_B, addr_of(w[3:0], r[1:0]), d);
            send_mem(OP_ST_H, addr_of(w[3:0], {r[2], 1'b0}), {d[15:0], d[31:16]});
            send_mem(OP_LD_W, addr_of(w[3:0], 2'd0), 32'd0);
        end

        d = next_random();
        send_mem(OP_LD_H, addr_of(4'd3, 2'd1), 32'd0);
        send_mem(OP_LD_HU, addr_of(4'd3, 2'd3), 32'd0);
        send_mem(OP_LD_W, addr_of(4'd3, 2'd1), 32'd0);
        send_mem(OP_LD_W, addr_of(4'd3, 2'd2), 32'd0);
        send_mem(OP_LD_W, addr_of(4'd3, 2'd3), 32'd0);
        send_mem(OP_ST_H, addr_of(4'd3, 2'd1), d);
        send_mem(OP_ST_W, addr_of(4'd3, 2'd2), d);
        send_mem(OP_ST_W, addr_of(4'd3, 2'd3), d);
        send_mem(OP_LD_W, addr_of(4'd3, 2'd0), 32'd0);

        // LL/SC pair, then an SC with the link already spent
        d = next_random();
        send_mem(OP_LL, addr_of(4'd5, 2'd0), 32'd0);
        send_mem(OP_SC, addr_of(4'd5, 2'd0), d);
        send_mem(OP_LD_W, addr_of(4'd5, 2'd0), 32'd0);
        send_mem(OP_SC, addr_of(4'd5, 2'd0), ~d);
        send_mem(OP_LD_W, addr_of(4'd5, 2'd0), 32'd0);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = next_random();
            d = next_random();
            if (r[31:29] == 3'd0) begin
                ex_i.valid = 1'b0;
                @(posedge clk_i);
                #10;
            end
            off = r[8] ? 2'd0 : r[7:6];
            send_mem(mem_op_e'(r[27:24] % 11), addr_of(r[15:12], off), d);
        end

        repeat (3) @(negedge clk_i);
        assert_fails = lsu_top_i.wb_master_i.props_i.fail_cnt;
        if (pend_cnt != 0) begin
            $display("%0d accepted items never produced a result", pend_cnt);
        end
        $display("Checks %0d, errors %0d, assertion failures %0d, missing results %0d",
                 check_cnt, err_cnt, assert_fails, pend_cnt);
        if (err_cnt == 0 && assert_fails == 0 && pend_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/data_ram.sv
`default_nettype none

`include "lsu_cfg.svh"

module data_ram
    import lsu_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [`LSU_ADDR_W-1:0] wb_adr_i,
    input  logic [`LSU_DATA_W-1:0] wb_dat_i,
    input  logic [SEL_W-1:0]       wb_sel_i,
    output logic                   wb_ack_o,
    output logic [`LSU_DATA_W-1:0] wb_dat_o
);

    localparam int AW = $clog2(`LSU_RAM_WORDS);

    logic [`LSU_DATA_W-1:0] mem_q [`LSU_RAM_WORDS];
    logic [AW-1:0]          word_addr;
    logic                   req_ok;

    assign word_addr = wb_adr_i[AW+1:2];

    // No new access in the ack cycle, one ack per request
    assign req_ok = wb_cyc_i & wb_stb_i & ~wb_ack_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= req_ok;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_ok) begin
            if (wb_we_i) begin
                for (int i = 0; i < SEL_W; i++) begin
                    if (wb_sel_i[i]) mem_q[word_addr][8*i +: 8] <= wb_dat_i[8*i +: 8];
                end
            end
            wb_dat_o <= mem_q[word_addr];
        end
    end

endmodule

`default_nettype wire

//--- design/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Data path word width
`define LSU_DATA_W 32

// Byte address width
`define LSU_ADDR_W 32

// Data RAM depth in words
`define LSU_RAM_WORDS 256

`endif

//--- design/lsu_pkg.sv
`default_nettype none

`include "lsu_cfg.svh"

package lsu_pkg;

    localparam int SEL_W = `LSU_DATA_W / 8;

    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_LD_B  = 4'd1,
        OP_LD_BU = 4'd2,
        OP_LD_H  = 4'd3,
        OP_LD_HU = 4'd4,
        OP_LD_W  = 4'd5,
        OP_ST_B  = 4'd6,
        OP_ST_H  = 4'd7,
        OP_ST_W  = 4'd8,
        OP_LL    = 4'd9,
        OP_SC    = 4'd10
    } mem_op_e;

    typedef enum logic [1:0] {
        BUS_IDLE = 2'd0,
        BUS_REQ  = 2'd1,
        BUS_DONE = 2'd2
    } bus_state_e;

    // Result of the execute stage
    typedef struct packed {
        logic                   valid;
        mem_op_e                op;
        logic [`LSU_ADDR_W-1:0] mem_addr;
        logic [`LSU_DATA_W-1:0] reg2;
        logic                   wreg;
        logic [4:0]             waddr;
        logic [`LSU_DATA_W-1:0] wdata;
    } ex_mem_t;

    typedef struct packed {
        logic                   ce;
        logic                   we;
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_DATA_W-1:0] data;
        logic [SEL_W-1:0]       sel;
    } mem_req_t;

    typedef struct packed {
        logic                   valid;
        logic                   wreg;
        logic [4:0]             waddr;
        logic [`LSU_DATA_W-1:0] wdata;
        logic                   excp_ale;
        logic                   llbit_we;
        logic                   llbit_value;
    } mem_wb_t;

    typedef struct packed {
        logic                   is_load;
        logic                   wreg;
        logic [4:0]             waddr;
        logic [`LSU_DATA_W-1:0] wdata;
    } mem_fwd_t;

endpackage

`default_nettype wire

//--- design/lsu_top.sv
`default_nettype none

`include "lsu_cfg.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  ex_mem_t  ex_i,
    output logic     stall_o,
    output mem_wb_t  wb_o,
    output mem_fwd_t fwd_o
);

    mem_req_t               req;
    mem_wb_t                stage_wb;
    logic                   data_ok;
    logic [`LSU_DATA_W-1:0] rdata;
    logic                   llbit;

    // Wishbone between master and RAM
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`LSU_ADDR_W-1:0] wb_adr;
    logic [`LSU_DATA_W-1:0] wb_dat_w;
    logic [`LSU_DATA_W-1:0] wb_dat_r;
    logic [SEL_W-1:0]       wb_sel;
    logic                   wb_ack;

    mem_stage mem_stage_i (
        .ex_i      (ex_i),
        .data_ok_i (data_ok),
        .rdata_i   (rdata),
        .llbit_i   (llbit),
        .req_o     (req),
        .wb_o      (stage_wb),
        .fwd_o     (fwd_o),
        .stall_o   (stall_o)
    );

    wb_master wb_master_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (req),
        .wb_ack_i  (wb_ack),
        .wb_dat_i  (wb_dat_r),
        .wb_cyc_o  (wb_cyc),
        .wb_stb_o  (wb_stb),
        .wb_we_o   (wb_we),
        .wb_adr_o  (wb_adr),
        .wb_dat_o  (wb_dat_w),
        .wb_sel_o  (wb_sel),
        .data_ok_o (data_ok),
        .rdata_o   (rdata)
    );

    data_ram data_ram_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_sel_i (wb_sel),
        .wb_ack_o (wb_ack),
        .wb_dat_o (wb_dat_r)
    );

    mem_wb_reg mem_wb_reg_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wb_i    (stage_wb),
        .wb_o    (wb_o),
        .llbit_o (llbit)
    );

endmodule

`default_nettype wire

//--- design/mem_stage.sv
`default_nettype none

`include "lsu_cfg.svh"

module mem_stage
    import lsu_pkg::*;
(
    input  ex_mem_t                ex_i,
    input  logic                   data_ok_i,
    input  logic [`LSU_DATA_W-1:0] rdata_i,
    input  logic                   llbit_i,
    output mem_req_t               req_o,
    output mem_wb_t                wb_o,
    output mem_fwd_t               fwd_o,
    output logic                   stall_o
);

    logic [1:0]  lane;
    logic [7:0]  rbyte;
    logic [15:0] rhalf;
    logic        misaligned;
    logic        is_load;

    assign lane = ex_i.mem_addr[1:0];

    // Addressed lanes of the returned word
    always_comb begin
        case (lane)
            2'd0: rbyte = rdata_i[7:0];
            2'd1: rbyte = rdata_i[15:8];
            2'd2: rbyte = rdata_i[23:16];
            default: rbyte = rdata_i[31:24];
        endcase
        rhalf = lane[1] ? rdata_i[31:16] : rdata_i[15:0];
    end

    always_comb begin
        case (ex_i.op)
            OP_LD_H, OP_LD_HU, OP_ST_H: misaligned = lane[0];
            OP_LD_W, OP_ST_W, OP_LL, OP_SC: misaligned = |lane;
            default: misaligned = 1'b0;
        endcase
    end

    always_comb begin
        req_o = '0;
        req_o.addr = ex_i.mem_addr;
        wb_o = '0;
        wb_o.wreg = ex_i.wreg;
        wb_o.waddr = ex_i.waddr;
        wb_o.wdata = ex_i.wdata;
        is_load = 1'b0;
        case (ex_i.op)
            OP_LD_B, OP_LD_BU: begin
                req_o.ce = 1'b1;
                req_o.sel = 4'b0001 << lane;
                wb_o.wreg = 1'b1;
                is_load = 1'b1;
                if (ex_i.op == OP_LD_B) begin
                    wb_o.wdata = {{24{rbyte[7]}}, rbyte};
                end else begin
                    wb_o.wdata = {24'b0, rbyte};
                end
            end
            OP_LD_H, OP_LD_HU: begin
                req_o.ce = 1'b1;
                req_o.sel = lane[1] ? 4'b1100 : 4'b0011;
                wb_o.wreg = 1'b1;
                is_load = 1'b1;
                if (ex_i.op == OP_LD_H) begin
                    wb_o.wdata = {{16{rhalf[15]}}, rhalf};
                end else begin
                    wb_o.wdata = {16'b0, rhalf};
                end
            end
            OP_LD_W, OP_LL: begin
                req_o.ce = 1'b1;
                req_o.sel = 4'b1111;
                wb_o.wreg = 1'b1;
                wb_o.wdata = rdata_i;
                is_load = 1'b1;
                // LL arms the link bit
                wb_o.llbit_we = ex_i.op == OP_LL;
                wb_o.llbit_value = 1'b1;
            end
            OP_ST_B: begin
                req_o.ce = 1'b1;
                req_o.we = 1'b1;
                req_o.sel = 4'b0001 << lane;
                req_o.data = {4{ex_i.reg2[7:0]}};
                wb_o.wreg = 1'b0;
            end
            OP_ST_H: begin
                req_o.ce = 1'b1;
                req_o.we = 1'b1;
                req_o.sel = lane[1] ? 4'b1100 : 4'b0011;
                req_o.data = {2{ex_i.reg2[15:0]}};
                wb_o.wreg = 1'b0;
            end
            OP_ST_W: begin
                req_o.ce = 1'b1;
                req_o.we = 1'b1;
                req_o.sel = 4'b1111;
                req_o.data = ex_i.reg2;
                wb_o.wreg = 1'b0;
            end
            OP_SC: begin
                wb_o.wreg = 1'b1;
                is_load = 1'b1;
                if (llbit_i) begin
                    req_o.ce = 1'b1;
                    req_o.we = 1'b1;
                    req_o.sel = 4'b1111;
                    req_o.data = ex_i.reg2;
                    wb_o.wdata = 32'd1;
                    wb_o.llbit_we = 1'b1;
                    wb_o.llbit_value = 1'b0;
                end else begin
                    wb_o.wdata = 32'd0;
                end
            end
            default: begin
            end
        endcase

        // Misaligned access goes nowhere and writes no register
        if (misaligned) begin
            req_o.ce = 1'b0;
            req_o.we = 1'b0;
            wb_o.wreg = 1'b0;
            wb_o.wdata = '0;
            wb_o.llbit_we = 1'b0;
            wb_o.excp_ale = 1'b1;
        end

        req_o.ce = req_o.ce & ex_i.valid;
        wb_o.valid = ex_i.valid & (~req_o.ce | data_ok_i);
    end

    assign stall_o = req_o.ce & ~data_ok_i;

    assign fwd_o.is_load = is_load & ex_i.valid;
    assign fwd_o.wreg = wb_o.wreg & ex_i.valid;
    assign fwd_o.waddr = wb_o.waddr;
    assign fwd_o.wdata = wb_o.wdata;

endmodule

`default_nettype wire

//--- design/mem_wb_reg.sv
`default_nettype none

module mem_wb_reg
    import lsu_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  mem_wb_t wb_i,
    output mem_wb_t wb_o,
    output logic    llbit_o
);

    mem_wb_t wb_q;
    logic    valid_q;
    logic    llbit_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            llbit_q <= 1'b0;
        end else begin
            valid_q <= wb_i.valid;
            // Link bit changes with the result that carries it
            if (wb_i.valid && wb_i.llbit_we) begin
                llbit_q <= wb_i.llbit_value;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        wb_q <= wb_i;
    end

    always_comb begin
        wb_o = wb_q;
        wb_o.valid = valid_q;
    end

    assign llbit_o = llbit_q;

endmodule

`default_nettype wire

//--- design/wb_master.sv
`default_nettype none

`include "lsu_cfg.svh"

module wb_master
    import lsu_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  mem_req_t               req_i,
    input  logic                   wb_ack_i,
    input  logic [`LSU_DATA_W-1:0] wb_dat_i,
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic                   wb_we_o,
    output logic [`LSU_ADDR_W-1:0] wb_adr_o,
    output logic [`LSU_DATA_W-1:0] wb_dat_o,
    output logic [SEL_W-1:0]       wb_sel_o,
    output logic                   data_ok_o,
    output logic [`LSU_DATA_W-1:0] rdata_o
);

    bus_state_e state_q;
    bus_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            BUS_IDLE: if (req_i.ce) state_d = BUS_REQ;
            BUS_REQ:  if (wb_ack_i) state_d = BUS_DONE;
            default:  state_d = BUS_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= BUS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request fields are held for the whole cycle
    always_ff @(posedge clk_i) begin
        if (state_q == BUS_IDLE && req_i.ce) begin
            wb_we_o  <= req_i.we;
            wb_adr_o <= req_i.addr;
            wb_dat_o <= req_i.data;
            wb_sel_o <= req_i.sel;
        end
        if (state_q == BUS_REQ && wb_ack_i) begin
            rdata_o <= wb_dat_i;
        end
    end

    assign wb_cyc_o  = state_q == BUS_REQ;
    assign wb_stb_o  = state_q == BUS_REQ;
    assign data_ok_o = state_q == BUS_DONE;

endmodule

`default_nettype wire

//--- lsu_top.f
+incdir+design
design/lsu_pkg.sv
design/mem_stage.sv
design/wb_master.sv
design/data_ram.sv
design/mem_wb_reg.sv
design/lsu_top.sv
bench/lsu_props.sv
bench/lsu_checker.sv
bench/lsu_tb.sv
